// File: hw/store_pkg.sv
/*
 * field store definitions
 * record layout shared by the extractor, tracker, arbiter and memory,
 * plus the store depth and address width
 */
package store_pkg;

	localparam int unsigned TAG_BITS    = 32;
	localparam int unsigned VALUE_BITS  = 256;
	localparam int unsigned STORE_DEPTH = 64;
	localparam int unsigned ADDR_BITS   = $clog2(STORE_DEPTH);

	typedef logic [ADDR_BITS-1:0] addr_t;

	typedef enum logic {
		REC_FIELD   = 1'b0,
		REC_SUMMARY = 1'b1
	} rec_kind_t;

	// summary records carry the field count in value[7:0]
	typedef struct packed {
		rec_kind_t               kind;
		logic                    som;
		logic [TAG_BITS-1:0]     tag;
		logic [VALUE_BITS-1:0]   value;
	} record_t;

endpackage

// File: hw/fix_pkg.sv
/*
 * FIX protocol definitions
 * character, tag and value types, ASCII delimiters and the
 * two tags the parser reacts to
 */
package fix_pkg;

	import store_pkg::*;

	typedef logic [7:0] byte_t;

	// tags and values are right-aligned, newest character in the low byte
	typedef logic [TAG_BITS-1:0]   tag_t;
	typedef logic [VALUE_BITS-1:0] value_t;

	typedef logic [7:0] count_t;

	localparam byte_t CHAR_SOH = 8'h01;
	localparam byte_t CHAR_EQ  = 8'h3d;

	// "8" begins a message
	localparam tag_t TAG_BEGIN    = 32'h0000_0038;
	// "10" closes it
	localparam tag_t TAG_CHECKSUM = 32'h0000_3130;

endpackage

// File: hw/store_wr_if.sv
/*
 * store write request
 * one writer presents a record with req and holds it until the
 * arbiter answers with gnt; the gnt cycle is the transfer
 */
`timescale 1ns/100ps

interface store_wr_if import store_pkg::*; ();

	logic    req;
	logic    gnt;
	record_t rec;

	modport writer (
		output req,
		output rec,
		input  gnt
	);

	modport arbiter (
		input  req,
		input  rec,
		output gnt
	);

endinterface

// File: hw/fix_tokenizer.sv
/*
 * FIX tokenizer
 * splits the byte stream into tag and value bytes and marks the
 * '=' and SOH delimiters with single-cycle pulses
 */
`timescale 1ns/100ps

module fix_tokenizer import fix_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  byte_t byte_i,
	input  logic  byte_valid_i,
	output byte_t data_o,
	output logic  tag_byte_o,
	output logic  value_byte_o,
	output logic  tag_end_o,
	output logic  value_end_o
);

	typedef enum logic {
		IN_TAG,
		IN_VALUE
	} tok_state_t;

	tok_state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= IN_TAG;
			tag_byte_o   <= 1'b0;
			value_byte_o <= 1'b0;
			tag_end_o    <= 1'b0;
			value_end_o  <= 1'b0;
		end else begin
			tag_byte_o   <= 1'b0;
			value_byte_o <= 1'b0;
			tag_end_o    <= 1'b0;
			value_end_o  <= 1'b0;
			if (byte_valid_i) begin
				case (state)
					IN_TAG: begin
						if (byte_i == CHAR_EQ) begin
							tag_end_o <= 1'b1;
							state     <= IN_VALUE;
						end else if (byte_i != CHAR_SOH) begin
							// stray SOH between fields is dropped
							tag_byte_o <= 1'b1;
						end
					end
					IN_VALUE: begin
						if (byte_i == CHAR_SOH) begin
							value_end_o <= 1'b1;
							state       <= IN_TAG;
						end else begin
							value_byte_o <= 1'b1;
						end
					end
					default: state <= IN_TAG;
				endcase
			end
		end
	end

	// byte travels alongside its strobe
	always_ff @(posedge clk) begin
		data_o <= byte_i;
	end

	a_one_delim: assert property (@(posedge clk) disable iff (rst)
		!(tag_end_o && value_end_o));

endmodule

// File: hw/fix_field_extractor.sv
/*
 * FIX field extractor
 * shifts tag and value characters into right-aligned registers,
 * flags the begin-string and checksum tags and queues one field
 * record per finished field for the store
 */
`timescale 1ns/100ps

module fix_field_extractor import fix_pkg::*, store_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  byte_t            data_i,
	input  logic             tag_byte_i,
	input  logic             value_byte_i,
	input  logic             tag_end_i,
	input  logic             value_end_i,
	output logic             field_done_o,
	output logic             is_begin_o,
	output logic             is_checksum_o,
	store_wr_if.writer       wr
);

	tag_t    tag_q;
	value_t  value_q;
	logic    tag_closed;
	logic    is_begin;
	logic    is_checksum;
	record_t new_rec;

	// two-entry queue with slot 0 as the head on the bus
	record_t slot0;
	record_t slot1;
	logic    valid0;
	logic    valid1;
	logic    pop;

	assign is_begin    = (tag_q == TAG_BEGIN);
	assign is_checksum = (tag_q == TAG_CHECKSUM);

	// oldest character falls off the top when a field is too long
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_q      <= '0;
			value_q    <= '0;
			tag_closed <= 1'b0;
		end else if (value_end_i) begin
			tag_q      <= '0;
			value_q    <= '0;
			tag_closed <= 1'b0;
		end else begin
			if (tag_byte_i && !tag_closed)
				tag_q <= {tag_q[$bits(tag_t)-9:0], data_i};
			if (tag_end_i)
				tag_closed <= 1'b1;
			if (value_byte_i)
				value_q <= {value_q[$bits(value_t)-9:0], data_i};
		end
	end

	always_comb begin
		new_rec.kind  = REC_FIELD;
		new_rec.som   = is_begin;
		new_rec.tag   = tag_q;
		new_rec.value = value_q;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			field_done_o  <= 1'b0;
			is_begin_o    <= 1'b0;
			is_checksum_o <= 1'b0;
		end else begin
			field_done_o  <= value_end_i;
			is_begin_o    <= value_end_i && is_begin;
			is_checksum_o <= value_end_i && is_checksum;
		end
	end

	assign pop = valid0 && wr.gnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid0 <= 1'b0;
			valid1 <= 1'b0;
		end else if (pop && value_end_i) begin
			valid0 <= 1'b1;
		end else if (pop) begin
			valid0 <= valid1;
			valid1 <= 1'b0;
		end else if (value_end_i) begin
			if (!valid0)
				valid0 <= 1'b1;
			else
				valid1 <= 1'b1;
		end
	end

	// payload is qualified by the valid flags
	always_ff @(posedge clk) begin
		if (pop) begin
			slot0 <= valid1 ? slot1 : new_rec;
			if (valid1 && value_end_i)
				slot1 <= new_rec;
		end else if (value_end_i) begin
			if (!valid0)
				slot0 <= new_rec;
			else if (!valid1)
				slot1 <= new_rec;
		end
	end

	assign wr.req = valid0;
	assign wr.rec = slot0;

	a_hold_rec: assert property (@(posedge clk) disable iff (rst)
		wr.req && !wr.gnt |=> wr.req && $stable(wr.rec));

endmodule

// File: hw/msg_tracker.sv
/*
 * message tracker
 * counts fields from the begin-string field to the checksum field
 * and requests one summary record per message
 */
`timescale 1ns/100ps

module msg_tracker import fix_pkg::*, store_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        field_done_i,
	input  logic        is_begin_i,
	input  logic        is_checksum_i,
	store_wr_if.writer  wr
);

	count_t  count_q;
	count_t  count_nxt;
	logic    req_q;
	record_t sum_rec;

	// begin field restarts the count at one
	assign count_nxt = is_begin_i ? count_t'(1) : count_q + count_t'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
			req_q   <= 1'b0;
		end else begin
			if (field_done_i)
				count_q <= count_nxt;
			if (field_done_i && is_checksum_i)
				req_q <= 1'b1;
			else if (wr.gnt)
				req_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (field_done_i && is_checksum_i) begin
			sum_rec.kind  <= REC_SUMMARY;
			sum_rec.som   <= 1'b0;
			sum_rec.tag   <= TAG_CHECKSUM;
			sum_rec.value <= {{(VALUE_BITS-$bits(count_t)){1'b0}}, count_nxt};
		end
	end

	assign wr.req = req_q;
	assign wr.rec = sum_rec;

endmodule

// File: hw/store_arbiter.sv
/*
 * store arbiter
 * fixed priority between the field and summary writers, owns the
 * write pointer and a saturating record count
 */
`timescale 1ns/100ps

module store_arbiter import store_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	store_wr_if.arbiter        fld,
	store_wr_if.arbiter        sum,
	output logic               we_o,
	output addr_t              waddr_o,
	output record_t            wdata_o,
	output logic [ADDR_BITS:0] rec_count_o,
	output logic               msg_done_o
);

	logic [ADDR_BITS:0] count_q;
	logic               full;

	assign full = (count_q == (ADDR_BITS+1)'(STORE_DEPTH));

	// field writer always wins
	assign fld.gnt = fld.req;
	assign sum.gnt = sum.req && !fld.req;

	// a full store still grants but drops the write
	assign we_o    = (fld.gnt || sum.gnt) && !full;
	assign waddr_o = count_q[ADDR_BITS-1:0];
	assign wdata_o = fld.gnt ? fld.rec : sum.rec;

	always_ff @(posedge clk) begin
		if (rst)
			count_q <= '0;
		else if (we_o)
			count_q <= count_q + 1'b1;
	end

	assign rec_count_o = count_q;
	assign msg_done_o  = sum.gnt;

	a_one_gnt: assert property (@(posedge clk) disable iff (rst)
		!(fld.gnt && sum.gnt));

endmodule

// File: hw/field_store.sv
/*
 * field store
 * record memory, one write port and one read port
 * with a single cycle of read latency
 */
`timescale 1ns/100ps

module field_store import store_pkg::*; (
	input  logic    clk,
	input  logic    we_i,
	input  addr_t   waddr_i,
	input  record_t wdata_i,
	input  addr_t   rd_addr_i,
	output record_t rd_data_o
);

	record_t mem [STORE_DEPTH];

	always_ff @(posedge clk) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// read is independent of the write port
	always_ff @(posedge clk) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

// File: hw/fix_parser_top.sv
/*
 * FIX parser top level
 * tokenizer, field extractor and message tracker writing
 * through an arbiter into a readable record store
 */
`timescale 1ns/100ps

module fix_parser_top import fix_pkg::*, store_pkg::*; (
	input  logic                        clk,
	input  logic                        rst,
	input  byte_t                       byte_i,
	input  logic                        byte_valid_i,
	input  addr_t                       rd_addr_i,
	output logic [$bits(record_t)-1:0]  rd_data_o,
	output logic [ADDR_BITS:0]          rec_count_o,
	output logic                        msg_done_o
);

	byte_t   tok_data;
	logic    tag_byte;
	logic    value_byte;
	logic    tag_end;
	logic    value_end;
	logic    field_done;
	logic    is_begin;
	logic    is_checksum;
	logic    we;
	addr_t   waddr;
	record_t wdata;
	record_t rd_rec;

	store_wr_if fld_wr ();
	store_wr_if sum_wr ();

	fix_tokenizer fix_tokenizer_inst (
		.clk          (clk),
		.rst          (rst),
		.byte_i       (byte_i),
		.byte_valid_i (byte_valid_i),
		.data_o       (tok_data),
		.tag_byte_o   (tag_byte),
		.value_byte_o (value_byte),
		.tag_end_o    (tag_end),
		.value_end_o  (value_end)
	);

	fix_field_extractor fix_field_extractor_inst (
		.clk           (clk),
		.rst           (rst),
		.data_i        (tok_data),
		.tag_byte_i    (tag_byte),
		.value_byte_i  (value_byte),
		.tag_end_i     (tag_end),
		.value_end_i   (value_end),
		.field_done_o  (field_done),
		.is_begin_o    (is_begin),
		.is_checksum_o (is_checksum),
		.wr            (fld_wr.writer)
	);

	msg_tracker msg_tracker_inst (
		.clk           (clk),
		.rst           (rst),
		.field_done_i  (field_done),
		.is_begin_i    (is_begin),
		.is_checksum_i (is_checksum),
		.wr            (sum_wr.writer)
	);

	store_arbiter store_arbiter_inst (
		.clk         (clk),
		.rst         (rst),
		.fld         (fld_wr.arbiter),
		.sum         (sum_wr.arbiter),
		.we_o        (we),
		.waddr_o     (waddr),
		.wdata_o     (wdata),
		.rec_count_o (rec_count_o),
		.msg_done_o  (msg_done_o)
	);

	field_store field_store_inst (
		.clk       (clk),
		.we_i      (we),
		.waddr_i   (waddr),
		.wdata_i   (wdata),
		.rd_addr_i (rd_addr_i),
		.rd_data_o (rd_rec)
	);

	assign rd_data_o = rd_rec;

endmodule

// File: tests/fix_parser_tb.sv
/*
 * FIX parser testbench
 * sends FIX messages with random values and idle gaps, then reads
 * the record store back and compares it with an expected record list
 */
`timescale 1ns/100ps

module fix_parser_tb import fix_pkg::*, store_pkg::*;;

	localparam int N_MSGS   = 8;
	localparam int GAP_MSGS = 3;

	logic                       clk;
	logic                       rst;
	byte_t                      byte_i;
	logic                       byte_valid_i;
	addr_t                      rd_addr_i;
	logic [$bits(record_t)-1:0] rd_data_o;
	logic [ADDR_BITS:0]         rec_count_o;
	logic                       msg_done_o;

	byte_t       stream [$];
	logic        gap_ok [$];
	record_t     expected [$];
	logic [31:0] lfsr;
	logic        gaps_on;
	logic        stream_ready;
	int          msg_fields;
	int          errors;
	int          checks;
	int          done_count;
	string       body_tags [6] = '{"9", "35", "49", "56", "34", "95432"};

	fix_parser_top fix_parser_top_inst (
		.clk          (clk),
		.rst          (rst),
		.byte_i       (byte_i),
		.byte_valid_i (byte_valid_i),
		.rd_addr_i    (rd_addr_i),
		.rd_data_o    (rd_data_o),
		.rec_count_o  (rec_count_o),
		.msg_done_o   (msg_done_o)
	);

	always #2 clk = ~clk;

	always @(negedge clk) begin
		if (!rst && msg_done_o)
			done_count++;
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) msg_done_o |=> !msg_done_o)
		else report_error("msg_done_o held high for more than one cycle");

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		rec_count_o <= STORE_DEPTH)
		else report_error("rec_count_o above the store depth");

	a_reset_state: assert property (@(posedge clk) rst |=> rec_count_o == 0 && !msg_done_o)
		else report_error("rec_count_o or msg_done_o not cleared by reset");

	task automatic report_error(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	// galois form with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// newest character lands in the low byte and the oldest falls off the top
	function automatic tag_t pack_tag(input string t);
		tag_t r;
		r = '0;
		for (int i = 0; i < t.len(); i++)
			r = {r[TAG_BITS-9:0], t[i]};
		return r;
	endfunction

	task automatic push_byte(input byte_t b);
		stream.push_back(b);
		gap_ok.push_back(gaps_on);
	endtask

	task automatic add_field(input string tag);
		record_t     rec;
		int unsigned len;
		int unsigned bits;
		byte_t       c;
		rec.kind  = REC_FIELD;
		rec.som   = (tag == "8");
		rec.tag   = pack_tag(tag);
		rec.value = '0;
		for (int i = 0; i < tag.len(); i++)
			push_byte(tag[i]);
		push_byte(8'h3d);
		// up to 40 characters so that long values get truncated
		take_bits(6, bits);
		len = 1 + bits % 40;
		for (int i = 0; i < len; i++) begin
			take_bits(6, bits);
			c = 8'h30 + bits[5:0];
			rec.value = {rec.value[VALUE_BITS-9:0], c};
			push_byte(c);
		end
		push_byte(8'h01);
		expected.push_back(rec);
		msg_fields++;
	endtask

	task automatic build_message(input int n_body);
		record_t sum;
		msg_fields = 0;
		add_field("8");
		for (int k = 0; k < n_body; k++)
			add_field(body_tags[k % 6]);
		add_field("10");
		sum.kind  = REC_SUMMARY;
		sum.som   = 1'b0;
		sum.tag   = pack_tag("10");
		sum.value = VALUE_BITS'(msg_fields);
		expected.push_back(sum);
	endtask

	task automatic send_stream;
		int unsigned gap;
		for (int i = 0; i < stream.size(); i++) begin
			take_bits(2, gap);
			if (gap_ok[i] && gap == 0) begin
				take_bits(1, gap);
				// SOH on the bus while idle must be ignored
				byte_i       = 8'h01;
				byte_valid_i = 1'b0;
				repeat (gap + 1) @(negedge clk);
			end
			byte_i       = stream[i];
			byte_valid_i = 1'b1;
			@(negedge clk);
		end
		byte_valid_i = 1'b0;
	endtask

	task automatic check_store;
		record_t got;
		record_t exp;
		for (int a = 0; a < STORE_DEPTH; a++) begin
			rd_addr_i = addr_t'(a);
			@(negedge clk);
			got = record_t'(rd_data_o);
			exp = expected[a];
			checks++;
			assert (got.kind == exp.kind)
				else report_error($sformatf("record %0d kind %0d, expected %0d", a, got.kind, exp.kind));
			assert (got.som == exp.som)
				else report_error($sformatf("record %0d som %0b, expected %0b", a, got.som, exp.som));
			assert (!got.som || got.tag == pack_tag("8"))
				else report_error($sformatf("record %0d has som set on tag %h", a, got.tag));
			assert (got.tag == exp.tag)
				else report_error($sformatf("record %0d tag %h, expected %h", a, got.tag, exp.tag));
			assert (got.value == exp.value)
				else report_error($sformatf("record %0d value %h, expected %h", a, got.value,
					exp.value));
		end
	endtask

	// watchdog sized from the stream length
	initial begin
		int unsigned wd_cycles;
		wait (stream_ready);
		wd_cycles = stream.size() * 4 + 200;
		#(wd_cycles * 4);
		$display("timeout: the DUT did not finish within %0d cycles", wd_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		byte_i       = '0;
		byte_valid_i = 1'b0;
		rd_addr_i    = '0;
		errors       = 0;
		checks       = 0;
		done_count   = 0;
		stream_ready = 1'b0;
		lfsr         = 32'd88156;
		// first messages get idle gaps and the rest run back to back
		for (int m = 0; m < N_MSGS; m++) begin
			gaps_on = (m < GAP_MSGS);
			build_message(4 + m % 4);
		end
		stream_ready = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		checks++;
		assert (rec_count_o == 0 && !msg_done_o)
			else report_error("outputs not idle after reset");
		send_stream();
		wait (done_count == N_MSGS);
		repeat (4) @(negedge clk);
		checks++;
		assert (rec_count_o == STORE_DEPTH)
			else report_error($sformatf("rec_count_o %0d, expected %0d", rec_count_o, STORE_DEPTH));
		check_store();
		checks++;
		assert (done_count == N_MSGS)
			else report_error($sformatf("%0d msg_done_o pulses, expected %0d", done_count, N_MSGS));
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: tb.f
hw/store_pkg.sv
hw/fix_pkg.sv
hw/store_wr_if.sv
hw/fix_tokenizer.sv
hw/fix_field_extractor.sv
hw/msg_tracker.sv
hw/store_arbiter.sv
hw/field_store.sv
hw/fix_parser_top.sv
tests/fix_parser_tb.sv

// File: Bender.yml
package:
  name: fix_parser

sources:
  - files:
      - hw/store_pkg.sv
      - hw/fix_pkg.sv
      - hw/store_wr_if.sv
      - hw/fix_tokenizer.sv
      - hw/fix_field_extractor.sv
      - hw/msg_tracker.sv
      - hw/store_arbiter.sv
      - hw/field_store.sv
      - hw/fix_parser_top.sv
  - target: test
    files:
      - tests/fix_parser_tb.sv
